/* source/trng_pkg.sv */
// TRNG shared definitions
// Widths, CRC constants, health limits and the FSM encodings

package trng_pkg;

    // --------------------
    // Sizes and limits
    localparam int RAW_WIDTH  = 32;    // Bits per packed entropy word
    localparam int SEED_WIDTH = 32;    // Bits per conditioned seed
    localparam int BYTE_WIDTH = 8;     // Host output slice
    localparam int COND_WORDS = 2;     // Raw words compressed into one seed
    localparam int RCT_LIMIT  = 24;    // Run of equal bits that fails the source
    localparam int BUF_DEPTH  = 4;     // Seed FIFO entries

    // --------------------
    // Vector types
    typedef logic [RAW_WIDTH-1:0]  raw_word_t;
    typedef logic [SEED_WIDTH-1:0] seed_t;
    typedef logic [BYTE_WIDTH-1:0] rand_byte_t;
    typedef logic [5:0]            bit_cnt_t;    // Counts 0..32, also run length

    // CRC-32, non-reflected
    localparam seed_t CRC_POLY = 32'h04C1_1DB7;
    localparam seed_t CRC_INIT = 32'hFFFF_FFFF;   // Register value out of reset

    // --------------------
    // Encodings
    typedef enum logic {
        REQ_BYTE = 1'b0,    // Low byte only
        REQ_WORD = 1'b1     // All four bytes, LSB first
    } rand_req_t;

    typedef enum logic {
        COND_IDLE  = 1'b0,
        COND_SHIFT = 1'b1
    } cond_state_t;

    typedef enum logic [1:0] {SERVE_IDLE, SERVE_WAIT, SERVE_SEND} serve_state_t;

endpackage

/* source/entropy_collector.sv */
// Entropy collector
// Samples strobed raw bits, packs them MSB first into 32-bit words
// and runs the repetition-count health test on the bit stream
`timescale 1ns/1ps

module entropy_collector (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                entropy_bit_i,     // Raw bit from the source
    input  logic                entropy_strobe_i,  // Bit is valid this cycle
    output logic                raw_valid_o,       // One cycle, word is complete
    output trng_pkg::raw_word_t raw_word_o,
    output logic                health_fail_o      // Sticky until reset
);

    trng_pkg::raw_word_t pack_q;       // Packing shift register
    trng_pkg::bit_cnt_t  bit_cnt;      // Bits in the current word
    trng_pkg::bit_cnt_t  run_cnt;      // Length of the current run, 0 = no bit yet
    logic                prev_bit;     // Last sampled bit
    logic                same_bit;
    logic                rct_trip;
    logic                word_done;

    // --------------------
    // Health test decode
    assign same_bit  = (run_cnt != '0) && (entropy_bit_i == prev_bit);
    assign rct_trip  = entropy_strobe_i && same_bit
                     && (int'(run_cnt) == trng_pkg::RCT_LIMIT - 1);
    assign word_done = entropy_strobe_i
                     && (bit_cnt == trng_pkg::bit_cnt_t'(trng_pkg::RAW_WIDTH - 1));

    // Packing path, payload only
    always_ff @(posedge clk) begin
        if (entropy_strobe_i) begin
            pack_q   <= {pack_q[trng_pkg::RAW_WIDTH-2:0], entropy_bit_i};  // MSB first
            prev_bit <= entropy_bit_i;    // Masked by run_cnt == 0 after reset
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            bit_cnt       <= '0;
            run_cnt       <= '0;
            raw_valid_o   <= 1'b0;
            health_fail_o <= 1'b0;
        end else begin
            // Word strobe, only from a healthy source
            raw_valid_o <= word_done && !health_fail_o && !rct_trip;

            if (entropy_strobe_i) begin
                if (word_done)
                    bit_cnt <= '0;
                else
                    bit_cnt <= bit_cnt + 1'b1;

                // Repetition count, saturates at the limit
                if (!same_bit)
                    run_cnt <= trng_pkg::bit_cnt_t'(1);
                else if (int'(run_cnt) < trng_pkg::RCT_LIMIT)
                    run_cnt <= run_cnt + 1'b1;
            end

            if (rct_trip)
                health_fail_o <= 1'b1;    // Latched failure
        end
    end

    assign raw_word_o = pack_q;    // Complete while raw_valid_o is high

endmodule

/* source/conditioner.sv */
// Entropy conditioner
// Feeds raw words bit-serially into a chained CRC-32 register and
// publishes the register as a seed after every COND_WORDS words
`timescale 1ns/1ps

module conditioner (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                raw_valid_i,   // One cycle, word from collector
    input  trng_pkg::raw_word_t raw_word_i,
    output logic                seed_valid_o,  // One cycle, seed_o is fresh
    output trng_pkg::seed_t     seed_o
);

    trng_pkg::cond_state_t                      state;
    trng_pkg::raw_word_t                        shreg;      // Word being absorbed
    trng_pkg::bit_cnt_t                         shift_cnt;
    trng_pkg::seed_t                            crc_q;      // Never cleared between seeds
    trng_pkg::seed_t                            crc_next;
    logic [$clog2(trng_pkg::COND_WORDS)-1:0]    word_cnt;   // Words absorbed into this seed
    logic                                       last_shift;
    logic                                       feedback;

    // --------------------
    // CRC step, shift left and fold in the poly on mismatch
    assign feedback   = crc_q[trng_pkg::SEED_WIDTH-1] ^ shreg[trng_pkg::RAW_WIDTH-1];
    assign crc_next   = {crc_q[trng_pkg::SEED_WIDTH-2:0], 1'b0}
                      ^ (feedback ? trng_pkg::CRC_POLY : '0);
    assign last_shift = (shift_cnt == trng_pkg::bit_cnt_t'(trng_pkg::RAW_WIDTH - 1));

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state        <= trng_pkg::COND_IDLE;
            shift_cnt    <= '0;
            word_cnt     <= '0;
            crc_q        <= trng_pkg::CRC_INIT;
            seed_valid_o <= 1'b0;
        end else begin
            seed_valid_o <= 1'b0;
            case (state)
                trng_pkg::COND_IDLE: begin
                    if (raw_valid_i) begin
                        state     <= trng_pkg::COND_SHIFT;
                        shift_cnt <= '0;
                    end
                end
                trng_pkg::COND_SHIFT: begin
                    crc_q     <= crc_next;    // One input bit per cycle
                    shift_cnt <= shift_cnt + 1'b1;
                    if (last_shift) begin
                        // Word finished, count it toward the seed
                        if (int'(word_cnt) == trng_pkg::COND_WORDS - 1) begin
                            word_cnt     <= '0;
                            seed_valid_o <= 1'b1;    // crc_q holds the seed next cycle
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                        end
                        shift_cnt <= '0;
                        // Back-to-back word lands on the final shift cycle
                        if (!raw_valid_i)
                            state <= trng_pkg::COND_IDLE;
                    end
                end
                default: state <= trng_pkg::COND_IDLE;
            endcase
        end
    end

    // Shift register loads on a word strobe, else drains MSB first
    always_ff @(posedge clk) begin
        if (raw_valid_i)
            shreg <= raw_word_i;
        else if (state == trng_pkg::COND_SHIFT)
            shreg <= {shreg[trng_pkg::RAW_WIDTH-2:0], 1'b0};
    end

    assign seed_o = crc_q;

endmodule

/* source/output_buffer.sv */
// Seed output buffer
// Small circular FIFO of seeds plus a request server that returns
// one byte or a whole word, one byte per cycle, LSB first
`timescale 1ns/1ps

module output_buffer (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 seed_valid_i,     // One cycle, new seed
    input  trng_pkg::seed_t      seed_i,
    input  logic                 rand_req_i,       // Host request pulse
    input  trng_pkg::rand_req_t  rand_req_type_i,
    output trng_pkg::rand_byte_t rand_byte_o,
    output logic                 rand_valid_o,
    output logic                 seed_drop_o       // One cycle, FIFO was full
);

    trng_pkg::seed_t                          fifo_mem [trng_pkg::BUF_DEPTH];
    logic [$clog2(trng_pkg::BUF_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(trng_pkg::BUF_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(trng_pkg::BUF_DEPTH):0]     fill_cnt;
    logic                                     fifo_full;
    logic                                     fifo_empty;
    logic                                     push;
    logic                                     pop;

    trng_pkg::serve_state_t                   state;
    trng_pkg::rand_req_t                      req_type;   // Captured at accept
    trng_pkg::seed_t                          out_word;   // Popped word being sent
    logic [$clog2(trng_pkg::SEED_WIDTH/trng_pkg::BYTE_WIDTH)-1:0] byte_idx;

    // --------------------
    // Seed FIFO
    assign fifo_full  = (int'(fill_cnt) == trng_pkg::BUF_DEPTH);
    assign fifo_empty = (fill_cnt == '0);
    assign push       = seed_valid_i && !fifo_full;   // Overflow drops the seed
    assign pop        = !fifo_empty
                      && ((state == trng_pkg::SERVE_IDLE && rand_req_i)
                          || state == trng_pkg::SERVE_WAIT);

    always_ff @(posedge clk) begin
        if (push)
            fifo_mem[wr_ptr] <= seed_i;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            fill_cnt    <= '0;
            seed_drop_o <= 1'b0;
        end else begin
            seed_drop_o <= seed_valid_i && fifo_full;
            if (push) wr_ptr <= wr_ptr + 1'b1;    // Pointers wrap at the power of two
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   fill_cnt <= fill_cnt + 1'b1;
                2'b01:   fill_cnt <= fill_cnt - 1'b1;
                default: fill_cnt <= fill_cnt;
            endcase
        end
    end

    // --------------------
    // Request server
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state    <= trng_pkg::SERVE_IDLE;
            req_type <= trng_pkg::REQ_BYTE;
            byte_idx <= '0;
        end else begin
            case (state)
                trng_pkg::SERVE_IDLE: begin
                    if (rand_req_i) begin
                        req_type <= rand_req_type_i;
                        byte_idx <= '0;
                        state    <= pop ? trng_pkg::SERVE_SEND : trng_pkg::SERVE_WAIT;
                    end
                end
                trng_pkg::SERVE_WAIT: begin
                    if (pop) state <= trng_pkg::SERVE_SEND;   // Seed showed up
                end
                trng_pkg::SERVE_SEND: begin
                    // Byte request ends after byte 0, rest of word is lost
                    if (req_type == trng_pkg::REQ_BYTE || &byte_idx)
                        state <= trng_pkg::SERVE_IDLE;
                    else
                        byte_idx <= byte_idx + 1'b1;
                end
                default: state <= trng_pkg::SERVE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop)
            out_word <= fifo_mem[rd_ptr];    // Head word, payload only
    end

    assign rand_valid_o = (state == trng_pkg::SERVE_SEND);
    assign rand_byte_o  = rand_valid_o
                        ? out_word[trng_pkg::BYTE_WIDTH*byte_idx +: trng_pkg::BYTE_WIDTH]
                        : '0;

endmodule

/* source/trng_top.sv */
// TRNG top level
// Collector, conditioner and output buffer chained with plain strobes
`timescale 1ns/1ps

module trng_top (
    input  logic                 clk,
    input  logic                 rst_n_i,           // Synchronous, active low
    input  logic                 entropy_bit_i,
    input  logic                 entropy_strobe_i,
    input  logic                 rand_req_i,        // Host request pulse
    input  trng_pkg::rand_req_t  rand_req_type_i,
    output trng_pkg::rand_byte_t rand_byte_o,
    output logic                 rand_valid_o,
    output logic                 health_fail_o,     // Source failed, sticky
    output logic                 seed_drop_o        // Seed lost to a full FIFO
);

    // --------------------
    // Internal links
    logic                raw_valid;     // Collector to conditioner
    trng_pkg::raw_word_t raw_word;
    logic                seed_valid;    // Conditioner to buffer
    trng_pkg::seed_t     seed;

    entropy_collector i_collector (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .entropy_bit_i    (entropy_bit_i),
        .entropy_strobe_i (entropy_strobe_i),
        .raw_valid_o      (raw_valid),
        .raw_word_o       (raw_word),
        .health_fail_o    (health_fail_o)
    );

    conditioner i_conditioner (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .raw_valid_i  (raw_valid),
        .raw_word_i   (raw_word),
        .seed_valid_o (seed_valid),
        .seed_o       (seed)
    );

    output_buffer i_buffer (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .seed_valid_i    (seed_valid),
        .seed_i          (seed),
        .rand_req_i      (rand_req_i),
        .rand_req_type_i (rand_req_type_i),
        .rand_byte_o     (rand_byte_o),
        .rand_valid_o    (rand_valid_o),
        .seed_drop_o     (seed_drop_o)
    );

endmodule

/* sim/tb_trng_top.sv */
// TRNG testbench
// Replays raw words and host requests from a stimulus file and checks the
// returned bytes, drop pulses and the health flag against the file
`timescale 1ns/1ps

module tb_trng_top;

    localparam int PERIOD      = 100;    // ns
    localparam int MAX_GAP     = 3;      // Idle cycles between strobes
    localparam int MAX_RECORDS = 40;
    localparam int WAIT_LIMIT  = 50;     // Cycles allowed for a drop pulse
    localparam int IDLE_WINDOW = 100;    // Cycles that must stay silent
    localparam longint TIMEOUT_NS = longint'(MAX_RECORDS) * 40 * (MAX_GAP + 1) * PERIOD
                                  + 200_000;

    logic                 clk;
    logic                 rst_n_i;
    logic                 entropy_bit_i;
    logic                 entropy_strobe_i;
    logic                 rand_req_i;
    trng_pkg::rand_req_t  rand_req_type_i;
    trng_pkg::rand_byte_t rand_byte_o;
    logic                 rand_valid_o;
    logic                 health_fail_o;
    logic                 seed_drop_o;

    logic [7:0]  rx_q [$];     // Bytes seen with rand_valid_o
    int          rx_cyc_q [$]; // Clock cycle of each received byte
    logic [7:0]  exp_q [$];    // Bytes still owed by the DUT
    int          cyc_cnt;
    int          drop_cnt;
    int          err_cnt;
    int          chk_cnt;
    logic [31:0] lcg_state;

    trng_top i_dut (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .entropy_bit_i    (entropy_bit_i),
        .entropy_strobe_i (entropy_strobe_i),
        .rand_req_i       (rand_req_i),
        .rand_req_type_i  (rand_req_type_i),
        .rand_byte_o      (rand_byte_o),
        .rand_valid_o     (rand_valid_o),
        .health_fail_o    (health_fail_o),
        .seed_drop_o      (seed_drop_o)
    );

    always #(PERIOD/2) clk = ~clk;

    // --------------------
    // Helpers
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;    // Numerical Recipes constants
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        chk_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("Mismatch at %0t ns: %s (got %h, expected %h)", $time, msg, actual,
                     expected);
        end
    endtask

    task automatic send_word(input logic [31:0] word);
        int gap;
        for (int i = 31; i >= 0; i--) begin
            @(negedge clk);
            entropy_strobe_i = 1'b1;
            entropy_bit_i    = word[i];    // MSB first
            lcg_state        = lcg_next(lcg_state);
            gap              = int'(lcg_state[17:16]);    // 0..3 idle cycles
            repeat (gap) begin
                @(negedge clk);
                entropy_strobe_i = 1'b0;
            end
        end
        @(negedge clk);
        entropy_strobe_i = 1'b0;
    endtask

    task automatic pulse_request(input logic req_type);
        @(negedge clk);
        rand_req_i      = 1'b1;
        rand_req_type_i = trng_pkg::rand_req_t'(req_type);
        @(negedge clk);
        rand_req_i      = 1'b0;
    endtask

    task automatic expect_bytes(input int fd, input logic req_type);
        logic [31:0] val;
        int          code;
        int          n;
        n = req_type ? 4 : 1;
        for (int i = 0; i < n; i++) begin
            code = $fscanf(fd, "%h", val);
            exp_q.push_back(val[7:0]);
        end
    endtask

    // Waits until every owed byte is in, then compares in order
    // Bytes of one request must land on back-to-back cycles
    task automatic collect_bytes();
        int first_cyc;
        int slot;
        while (rx_q.size() < exp_q.size())
            @(negedge clk);
        first_cyc = (rx_cyc_q.size() > 0) ? rx_cyc_q[0] : 0;
        slot      = 0;
        while (exp_q.size() > 0) begin
            check_value(32'(rx_cyc_q.pop_front() - first_cyc), 32'(slot), "output byte cycle");
            check_value(32'(rx_q.pop_front()), 32'(exp_q.pop_front()), "output byte");
            slot++;
        end
    endtask

    // --------------------
    // Monitor samples registered outputs at the rising edge
    always @(posedge clk) begin
        cyc_cnt++;
        if (rst_n_i) begin
            if (rand_valid_o) begin
                rx_q.push_back(rand_byte_o);
                rx_cyc_q.push_back(cyc_cnt);
            end
            if (seed_drop_o)
                drop_cnt++;
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired, the DUT stopped answering and the run was cut short");
        $display("Simulation finished: FAIL");
        $finish;
    end

    // --------------------
    // Main sequence
    initial begin
        int          fd;
        int          code;
        int          waited;
        logic [63:0] tag;
        logic [31:0] val;
        logic [8*200-1:0] line;

        clk              = 1'b0;
        rst_n_i          = 1'b0;
        entropy_bit_i    = 1'b0;
        entropy_strobe_i = 1'b0;
        rand_req_i       = 1'b0;
        rand_req_type_i  = trng_pkg::REQ_BYTE;
        cyc_cnt          = 0;
        drop_cnt         = 0;
        err_cnt          = 0;
        chk_cnt          = 0;
        lcg_state        = 32'haaf5_0266;

        repeat (8) @(posedge clk);    // Reset held for 8 cycles
        @(negedge clk);
        rst_n_i = 1'b1;

        // Quiet outputs after reset
        check_value(32'(rand_valid_o), 0, "rand_valid_o after reset");
        check_value(32'(rand_byte_o), 0, "rand_byte_o after reset");
        check_value(32'(seed_drop_o), 0, "seed_drop_o after reset");
        check_value(32'(health_fail_o), 0, "health_fail_o after reset");
        repeat (10) @(negedge clk);
        check_value(rx_q.size(), 0, "bytes before any entropy");

        fd = $fopen("sim/trng_stimulus.txt", "r");
        if (fd == 0) begin
            $display("The stimulus file was not found, nothing was tested");
            err_cnt++;
        end else begin
            forever begin
                code = $fscanf(fd, "%s", tag);
                if (code != 1)
                    break;
                if (tag == "#") begin
                    code = $fgets(line, fd);    // Skip comment text
                end else if (tag == "RAW") begin
                    code = $fscanf(fd, "%h", val);
                    send_word(val);
                end else if (tag == "REQ") begin
                    code = $fscanf(fd, "%h", val);
                    expect_bytes(fd, val[0]);
                    pulse_request(val[0]);
                    collect_bytes();
                end else if (tag == "PEND") begin
                    // Request on an empty FIFO and a stray pulse of the other type in WAIT
                    code = $fscanf(fd, "%h", val);
                    expect_bytes(fd, val[0]);
                    pulse_request(val[0]);
                    @(negedge clk);
                    pulse_request(!val[0]);
                end else if (tag == "SYNC") begin
                    collect_bytes();
                    repeat (8) @(negedge clk);
                    check_value(rx_q.size(), 0, "extra bytes after service");
                end else if (tag == "DROPS") begin
                    code = $fscanf(fd, "%d", val);
                    waited = 0;
                    while (drop_cnt < int'(val) && waited < WAIT_LIMIT) begin
                        @(negedge clk);
                        waited++;
                    end
                    repeat (4) @(negedge clk);
                    check_value(drop_cnt, val, "seed_drop_o pulse count");
                end else if (tag == "FAIL") begin
                    $display("Entering health test section at %0t ns", $time);
                end else if (tag == "HEALTH") begin
                    code = $fscanf(fd, "%h", val);
                    check_value(32'(health_fail_o), val, "health_fail_o");
                end else if (tag == "NONE") begin
                    code = $fscanf(fd, "%h", val);
                    pulse_request(val[0]);
                    repeat (IDLE_WINDOW) @(negedge clk);
                    check_value(rx_q.size(), 0, "bytes from a failed source");
                end else begin
                    $display("Unknown record in the stimulus file at %0t ns", $time);
                    err_cnt++;
                end
            end
            $fclose(fd);
        end

        if (rx_q.size() != 0) begin
            $display("The DUT sent %0d bytes that nobody asked for", rx_q.size());
            err_cnt++;
        end

        $display("Checks: %0d, errors: %0d, drops seen: %0d", chk_cnt, err_cnt, drop_cnt);
        if (err_cnt == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* sim/trng_stimulus.txt */
# Records: RAW word | REQ type bytes | PEND type bytes | SYNC | DROPS count
# FAIL | HEALTH level | NONE type ; type 0 = byte, 1 = word, bytes LSB first
RAW FFFEFFFF
RAW 01D8AC86
REQ 1 B7 1D C1 04
RAW 04C11DB5
RAW 09823B6A
RAW 130476D4
RAW 2608EDA8
REQ 0 DC
REQ 1 70 DB 11 4C
PEND 1 77 70 86 34
RAW 4C11DB50
RAW 9823B6A0
SYNC
RAW 348670F7
RAW 690CE1EE
RAW D219C3DC
RAW A0F29A0F
RAW 452429A9
RAW 8A485352
RAW 1051BB13
RAW 20A37626
RAW 4146EC4C
RAW 828DD898
DROPS 1
REQ 1 DC C1 19 D2
REQ 1 A9 21 24 45
REQ 1 13 9B 51 10
REQ 1 4C 6C 46 41
FAIL
RAW 00FFFFFF
HEALTH 1
RAW 5A5A5A5A
RAW A5A5A5A5
NONE 1

/* tb.f */
source/trng_pkg.sv
source/entropy_collector.sv
source/conditioner.sv
source/output_buffer.sv
source/trng_top.sv
sim/tb_trng_top.sv

/* Makefile */
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f tb.f --top-module tb_trng_top -o Vtb_trng_top

run: build
	./obj_dir/Vtb_trng_top | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then \
		echo "Run failed"; exit 1; \
	fi
	@grep -q "Simulation finished: PASS" sim.log

lint:
	verilator --lint-only --timing -f tb.f --top-module tb_trng_top
	verilator --lint-only source/trng_pkg.sv source/entropy_collector.sv \
		source/conditioner.sv source/output_buffer.sv source/trng_top.sv \
		--top-module trng_top

clean:
	rm -rf obj_dir sim.log
